/* rtl/phy_mgmt_pkg.sv */
package phy_mgmt_pkg;

    // gigabit PHY strap address on the MDIO bus
    localparam logic [4:0] PHY_ADDR = 5'd3;

    // extended register access through REGCR/ADDAR
    localparam logic [4:0] REG_REGCR = 5'h0D;
    localparam logic [4:0] REG_ADDAR = 5'h0E;

    // REGCR function field: 00 address, 01 data without post increment
    localparam logic [15:0] REGCR_ADDR_CMD = 16'h001F;
    localparam logic [15:0] REGCR_DATA_CMD = 16'h401F;

    // MDC half period minus one, so one MDC period is 8 clocks
    localparam logic [7:0] MDIO_PRESCALE = 8'd3;

    // start-up delay before the first PHY write, shortened for simulation
    localparam logic [19:0] INIT_DELAY_CYCLES = 20'd1000;

    // front-panel debounce
    localparam logic [15:0] DEBOUNCE_RATE = 16'd16;
    localparam int DEBOUNCE_DEPTH = 4;

    // 5 buttons plus 4 switches
    localparam int GPIO_WIDTH = 9;

    // block lock flags of the two QSFP28 cages
    localparam int NUM_LANES = 8;

    // clause-22 opcodes
    typedef enum logic [1:0] {
        mdio_op_write = 2'b01,
        mdio_op_read  = 2'b10
    } mdio_op_e;

    // configuration sequencer states
    typedef enum logic [1:0] {
        seq_delay,
        seq_issue,
        seq_wait,
        seq_done
    } seq_state_e;

    // MDIO master states
    typedef enum logic {
        mdio_idle,
        mdio_shift
    } mdio_state_e;

endpackage

/* rtl/phy_cfg_sequencer.sv */
`timescale 1ns/100ps

module phy_cfg_sequencer (
    input  logic        clk_125mhz_int,
    input  logic        gt_tx_reset,
    input  logic        cmd_ready_i,
    output logic [4:0]  cmd_reg_addr_o,
    output logic [15:0] cmd_data_o,
    output logic        cmd_valid_o,
    output logic        cfg_done_o
);

    import phy_mgmt_pkg::*;

    seq_state_e  state_q;
    logic [19:0] delay_cnt_q;
    logic [3:0]  step_q;
    logic [15:0] target_addr;
    logic [15:0] target_data;

    // one extended register per group of four steps
    always_comb begin
        case (step_q[3:2])
            2'd0: begin
                // CFG4, SGMII autoneg timer 11 ms
                target_addr = 16'h0031;
                target_data = 16'h0070;
            end
            2'd1: begin
                // SGMIICTL1, SGMII clock output on
                target_addr = 16'h00D3;
                target_data = 16'h4000;
            end
            default: begin
                // 10M_SGMII_CFG, 10 Mbps over SGMII
                target_addr = 16'h016F;
                target_data = 16'h0015;
            end
        endcase
    end

    // address phase then data phase, each via REGCR then ADDAR
    always_comb begin
        case (step_q[1:0])
            2'd0: begin
                cmd_reg_addr_o = REG_REGCR;
                cmd_data_o     = REGCR_ADDR_CMD;
            end
            2'd1: begin
                cmd_reg_addr_o = REG_ADDAR;
                cmd_data_o     = target_addr;
            end
            2'd2: begin
                cmd_reg_addr_o = REG_REGCR;
                cmd_data_o     = REGCR_DATA_CMD;
            end
            default: begin
                cmd_reg_addr_o = REG_ADDAR;
                cmd_data_o     = target_data;
            end
        endcase
    end

    always_ff @(posedge clk_125mhz_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            state_q     <= seq_delay;
            delay_cnt_q <= INIT_DELAY_CYCLES;
            step_q      <= 4'd0;
            cmd_valid_o <= 1'b0;
            cfg_done_o  <= 1'b0;
        end else begin
            case (state_q)
                seq_delay: begin
                    delay_cnt_q <= delay_cnt_q - 20'd1;
                    if (delay_cnt_q == 20'd1) begin
                        cmd_valid_o <= 1'b1;
                        state_q     <= seq_issue;
                    end
                end
                seq_issue: begin
                    // valid is always up here, so ready alone completes the transfer
                    if (cmd_ready_i) begin
                        cmd_valid_o <= 1'b0;
                        if (step_q == 4'd11) begin
                            cfg_done_o <= 1'b1;
                            state_q    <= seq_done;
                        end else begin
                            step_q  <= step_q + 4'd1;
                            state_q <= seq_wait;
                        end
                    end
                end
                seq_wait: begin
                    // ready stays low for the whole frame
                    if (cmd_ready_i) begin
                        cmd_valid_o <= 1'b1;
                        state_q     <= seq_issue;
                    end
                end
                default: begin
                    state_q <= seq_done;
                end
            endcase
        end
    end

    // pending command holds until the master takes it
    a_cmd_hold: assert property (@(posedge clk_125mhz_int) disable iff (gt_tx_reset)
        cmd_valid_o && !cmd_ready_i |=>
            cmd_valid_o && $stable(cmd_reg_addr_o) && $stable(cmd_data_o));

endmodule

/* rtl/mdio_master.sv */
`timescale 1ns/100ps

module mdio_master (
    input  logic        clk_125mhz_int,
    input  logic        gt_tx_reset,
    input  logic [4:0]  cmd_reg_addr_i,
    input  logic [15:0] cmd_data_i,
    input  logic        cmd_valid_i,
    output logic        cmd_ready_o,
    output logic        mdc_o,
    output logic        mdio_o,
    output logic        mdio_t_o
);

    import phy_mgmt_pkg::*;

    mdio_state_e state_q;
    logic [7:0]  prescale_q;
    logic [5:0]  bit_cnt_q;
    logic [63:0] shift_q;
    logic [63:0] frame;
    logic        accept;
    logic        mdc_wrap;
    logic        mdc_fall;

    // preamble, ST, OP, PHYAD, REGAD, TA, data
    assign frame = {
        32'hffff_ffff,
        2'b01,
        mdio_op_write,
        PHY_ADDR,
        cmd_reg_addr_i,
        2'b10,
        cmd_data_i
    };

    assign cmd_ready_o = (state_q == mdio_idle);
    assign accept      = cmd_valid_i && cmd_ready_o;

    // half period elapsed
    assign mdc_wrap = (prescale_q == MDIO_PRESCALE);
    // next bit goes out as mdc drops
    assign mdc_fall = mdc_wrap && mdc_o;

    always_ff @(posedge clk_125mhz_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            state_q    <= mdio_idle;
            prescale_q <= 8'd0;
            bit_cnt_q  <= 6'd0;
            mdc_o      <= 1'b0;
            mdio_o     <= 1'b1;
            mdio_t_o   <= 1'b1;
        end else begin
            case (state_q)
                mdio_idle: begin
                    if (accept) begin
                        // first preamble bit is driven while mdc is still low
                        state_q    <= mdio_shift;
                        prescale_q <= 8'd0;
                        bit_cnt_q  <= 6'd0;
                        mdio_o     <= frame[63];
                        mdio_t_o   <= 1'b0;
                    end
                end
                default: begin
                    if (mdc_wrap) begin
                        prescale_q <= 8'd0;
                        mdc_o      <= ~mdc_o;
                    end else begin
                        prescale_q <= prescale_q + 8'd1;
                    end

                    if (mdc_fall) begin
                        if (bit_cnt_q == 6'd63) begin
                            // end of the 64th period, release the line
                            state_q  <= mdio_idle;
                            mdio_o   <= 1'b1;
                            mdio_t_o <= 1'b1;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 6'd1;
                            mdio_o    <= shift_q[63];
                        end
                    end
                end
            endcase
        end
    end

    // remaining frame bits, MSB next
    always_ff @(posedge clk_125mhz_int) begin
        if (accept) begin
            shift_q <= {frame[62:0], 1'b0};
        end else if (mdc_fall) begin
            shift_q <= {shift_q[62:0], 1'b0};
        end
    end

    // bus released whenever no frame is running
    a_idle_released: assert property (@(posedge clk_125mhz_int) disable iff (gt_tx_reset)
        state_q == mdio_idle |-> mdio_t_o);

    // data only moves on the falling mdc edge
    a_mdio_setup: assert property (@(posedge clk_125mhz_int) disable iff (gt_tx_reset)
        mdc_o |-> $stable(mdio_o));

endmodule

/* rtl/board_io.sv */
`timescale 1ns/100ps

module board_io (
    input  logic                                 clk_125mhz_int,
    input  logic                                 gt_tx_reset,
    input  logic [4:0]                           btn_i,
    input  logic [3:0]                           sw_i,
    input  logic [phy_mgmt_pkg::NUM_LANES-1:0]   lane_lock_i,
    output logic [7:0]                           led_o
);

    import phy_mgmt_pkg::*;

    logic [15:0]                               rate_cnt_q;
    logic                                      sample;
    logic [GPIO_WIDTH-1:0]                     gpio_raw;
    logic [GPIO_WIDTH-1:0][DEBOUNCE_DEPTH-1:0] hist_q;
    logic [GPIO_WIDTH-1:0]                     gpio_db_q;
    logic [4:0]                                btn_db;
    logic [3:0]                                sw_db;

    // up, left, down, right, center, then sw[3:0]
    assign gpio_raw = {btn_i, sw_i};
    assign btn_db   = gpio_db_q[GPIO_WIDTH-1:4];
    assign sw_db    = gpio_db_q[3:0];

    // shared sample tick for all inputs
    assign sample = (rate_cnt_q == DEBOUNCE_RATE - 16'd1);

    always_ff @(posedge clk_125mhz_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            rate_cnt_q <= 16'd0;
        end else if (sample) begin
            rate_cnt_q <= 16'd0;
        end else begin
            rate_cnt_q <= rate_cnt_q + 16'd1;
        end
    end

    always_ff @(posedge clk_125mhz_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            hist_q    <= '0;
            gpio_db_q <= '0;
        end else begin
            for (int i = 0; i < GPIO_WIDTH; i++) begin
                if (sample) begin
                    hist_q[i] <= {hist_q[i][DEBOUNCE_DEPTH-2:0], gpio_raw[i]};
                end
                // hold the old value until every sample agrees
                if (&hist_q[i]) begin
                    gpio_db_q[i] <= 1'b1;
                end else if (~|hist_q[i]) begin
                    gpio_db_q[i] <= 1'b0;
                end
            end
        end
    end

    // sw[0] picks lane status over the front panel
    always_ff @(posedge clk_125mhz_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            led_o <= 8'd0;
        end else if (sw_db[0]) begin
            led_o <= lane_lock_i;
        end else begin
            led_o <= {btn_db, sw_db[3:1]};
        end
    end

endmodule

/* rtl/board_mgmt_top.sv */
`timescale 1ns/100ps

module board_mgmt_top (
    input  logic                               clk_125mhz_int,
    input  logic                               gt_tx_reset,
    input  logic [4:0]                         btn_i,
    input  logic [3:0]                         sw_i,
    input  logic [phy_mgmt_pkg::NUM_LANES-1:0] lane_lock_i,
    output logic [7:0]                         led_o,
    output logic                               mdc_o,
    output logic                               mdio_o,
    output logic                               mdio_t_o,
    output logic                               cfg_done_o
);

    // sequencer to MDIO master command channel
    logic [4:0]  cmd_reg_addr;
    logic [15:0] cmd_data;
    logic        cmd_valid;
    logic        cmd_ready;

    phy_cfg_sequencer i_seq (
        .clk_125mhz_int (clk_125mhz_int),
        .gt_tx_reset    (gt_tx_reset),
        .cmd_ready_i    (cmd_ready),
        .cmd_reg_addr_o (cmd_reg_addr),
        .cmd_data_o     (cmd_data),
        .cmd_valid_o    (cmd_valid),
        .cfg_done_o     (cfg_done_o)
    );

    mdio_master i_mdio (
        .clk_125mhz_int (clk_125mhz_int),
        .gt_tx_reset    (gt_tx_reset),
        .cmd_reg_addr_i (cmd_reg_addr),
        .cmd_data_i     (cmd_data),
        .cmd_valid_i    (cmd_valid),
        .cmd_ready_o    (cmd_ready),
        .mdc_o          (mdc_o),
        .mdio_o         (mdio_o),
        .mdio_t_o       (mdio_t_o)
    );

    // front panel runs alongside the PHY setup
    board_io i_board_io (
        .clk_125mhz_int (clk_125mhz_int),
        .gt_tx_reset    (gt_tx_reset),
        .btn_i          (btn_i),
        .sw_i           (sw_i),
        .lane_lock_i    (lane_lock_i),
        .led_o          (led_o)
    );

endmodule

/* tb/mdio_phy_model.sv */
`timescale 1ns/100ps

module mdio_phy_model (
    input  logic        mdc_i,
    input  logic        mdio_i,
    input  logic        mdio_t_i,
    output int          frame_cnt_o,
    output int          bit_cnt_o,
    output int          preamble_o,
    output logic [1:0]  start_o,
    output logic [1:0]  op_o,
    output logic [4:0]  phy_addr_o,
    output logic [4:0]  reg_addr_o,
    output logic [1:0]  ta_o,
    output logic [15:0] data_o
);

    logic [63:0] capture;
    int          nbits;
    int          frame_base;
    int          frame_cnt;
    int          last_bits;
    int          last_preamble;

    assign frame_cnt_o = frame_cnt;
    assign bit_cnt_o   = last_bits;
    assign preamble_o  = last_preamble;

    // ones before the first zero, newest bit sits at position 0
    function automatic int count_preamble(input logic [63:0] bits, input int len);
        int n;
        int top;
        n   = 0;
        top = (len > 64) ? 64 : len;
        for (int i = top - 1; i >= 0; i--) begin
            if (!bits[i]) begin
                break;
            end
            n++;
        end
        return n;
    endfunction

    // slave latches the line on rising MDC while the master drives it
    always @(posedge mdc_i) begin
        if (!mdio_t_i) begin
            capture <= {capture[62:0], mdio_i};
            nbits   <= nbits + 1;
        end
    end

    // line released, so the frame is complete
    // running bit total minus the total at the previous release
    always @(posedge mdio_t_i) begin
        if (nbits != frame_base) begin
            last_bits     <= nbits - frame_base;
            last_preamble <= count_preamble(capture, nbits - frame_base);
            start_o       <= capture[31:30];
            op_o          <= capture[29:28];
            phy_addr_o    <= capture[27:23];
            reg_addr_o    <= capture[22:18];
            ta_o          <= capture[17:16];
            data_o        <= capture[15:0];
            frame_cnt     <= frame_cnt + 1;
            frame_base    <= nbits;
        end
    end

endmodule

/* tb/tb_board_mgmt.sv */
`timescale 1ns/100ps

module tb_board_mgmt;

    import phy_mgmt_pkg::*;

    localparam int INIT_DELAY     = int'(INIT_DELAY_CYCLES);
    localparam int SETTLE_CYCLES  = (DEBOUNCE_DEPTH + 1) * int'(DEBOUNCE_RATE) + 2;
    localparam int TIMEOUT_CYCLES = INIT_DELAY + 12 * 520 + 4000;
    localparam int NUM_WRITES     = 12;

    logic                 clk_125mhz_int;
    logic                 gt_tx_reset;
    logic [4:0]           btn;
    logic [3:0]           sw;
    logic [NUM_LANES-1:0] lane_lock;
    logic [7:0]           led;
    logic                 mdc;
    logic                 mdio;
    logic                 mdio_t;
    logic                 cfg_done;

    int                   phy_frames;
    int                   phy_bits;
    int                   phy_preamble;
    logic [1:0]           phy_start;
    logic [1:0]           phy_op;
    logic [1:0]           phy_ta;
    logic [4:0]           phy_addr;
    logic [4:0]           phy_reg;
    logic [15:0]          phy_data;

    logic [4:0]           exp_reg [NUM_WRITES];
    logic [15:0]          exp_data [NUM_WRITES];
    logic [31:0]          lcg_state = 32'd3;
    logic                 done_activity_seen = 1'b0;
    int                   mismatches;
    int                   failures;
    int                   frames_checked;
    int                   frames_started;
    int                   led_checks;
    int                   rel_cnt;
    int                   run_len;
    int                   last_run;
    int                   cycle_cnt;
    int                   hold_cnt;
    int                   stable_cnt;

    board_mgmt_top i_dut (
        .clk_125mhz_int (clk_125mhz_int),
        .gt_tx_reset    (gt_tx_reset),
        .btn_i          (btn),
        .sw_i           (sw),
        .lane_lock_i    (lane_lock),
        .led_o          (led),
        .mdc_o          (mdc),
        .mdio_o         (mdio),
        .mdio_t_o       (mdio_t),
        .cfg_done_o     (cfg_done)
    );

    mdio_phy_model i_phy (
        .mdc_i       (mdc),
        .mdio_i      (mdio),
        .mdio_t_i    (mdio_t),
        .frame_cnt_o (phy_frames),
        .bit_cnt_o   (phy_bits),
        .preamble_o  (phy_preamble),
        .start_o     (phy_start),
        .op_o        (phy_op),
        .phy_addr_o  (phy_addr),
        .reg_addr_o  (phy_reg),
        .ta_o        (phy_ta),
        .data_o      (phy_data)
    );

    initial clk_125mhz_int = 1'b0;
    always #4 clk_125mhz_int = ~clk_125mhz_int;

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[31:16]);
    endfunction

    // REGCR address, ADDAR target, REGCR data, ADDAR value per extended register
    task automatic build_write_list();
        logic [15:0] target_addr [3];
        logic [15:0] target_data [3];
        target_addr = '{16'h0031, 16'h00D3, 16'h016F};
        target_data = '{16'h0070, 16'h4000, 16'h0015};
        for (int t = 0; t < 3; t++) begin
            exp_reg[4*t]    = REG_REGCR;
            exp_data[4*t]   = REGCR_ADDR_CMD;
            exp_reg[4*t+1]  = REG_ADDAR;
            exp_data[4*t+1] = target_addr[t];
            exp_reg[4*t+2]  = REG_REGCR;
            exp_data[4*t+2] = REGCR_DATA_CMD;
            exp_reg[4*t+3]  = REG_ADDAR;
            exp_data[4*t+3] = target_data[t];
        end
    endtask

    task automatic compare_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            mismatches++;
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("%s", msg);
    endtask

    task automatic print_counts();
        $display("mismatches: %0d, other failures: %0d, frames checked: %0d, led checks: %0d",
                 mismatches, failures, frames_checked, led_checks);
    endtask

    task automatic verify_idle_outputs(input string phase);
        compare_value({phase, " mdio_t_o"}, 1, int'(mdio_t));
        compare_value({phase, " mdio_o"}, 1, int'(mdio));
        compare_value({phase, " mdc_o"}, 0, int'(mdc));
        compare_value({phase, " cfg_done_o"}, 0, int'(cfg_done));
        compare_value({phase, " led_o"}, 0, int'(led));
    endtask

    task automatic inspect_frame();
        int idx;
        idx = frames_checked;
        if (idx >= NUM_WRITES) begin
            assert (0) else report_failure("MDIO frame seen after the twelfth write");
        end else begin
            compare_value($sformatf("frame %0d bits", idx), 64, phy_bits);
            compare_value($sformatf("frame %0d preamble", idx), 32, phy_preamble);
            compare_value($sformatf("frame %0d start", idx), 1, int'(phy_start));
            compare_value($sformatf("frame %0d opcode", idx), 1, int'(phy_op));
            compare_value($sformatf("frame %0d phy address", idx), 3, int'(phy_addr));
            compare_value($sformatf("frame %0d turnaround", idx), 2, int'(phy_ta));
            compare_value($sformatf("frame %0d register", idx), int'(exp_reg[idx]),
                          int'(phy_reg));
            compare_value($sformatf("frame %0d data", idx), int'(exp_data[idx]),
                          int'(phy_data));
            compare_value($sformatf("frame %0d length", idx), 512, last_run);
        end
        frames_checked++;
    endtask

    // one clock of front-panel stimulus, LED checked once inputs have settled
    task automatic drive_front_panel_step();
        int         r;
        logic [7:0] expected;
        @(posedge clk_125mhz_int);
        stable_cnt++;
        if (stable_cnt >= SETTLE_CYCLES) begin
            expected = sw[0] ? lane_lock : {btn, sw[3:1]};
            led_checks++;
            compare_value($sformatf("led select sw0=%0d", sw[0]), int'(expected), int'(led));
        end
        if (hold_cnt == 0) begin
            r = next_rand();
            btn <= r[4:0];
            sw  <= r[8:5];
            r = next_rand();
            lane_lock <= r[NUM_LANES-1:0];
            r = next_rand();
            hold_cnt   = (r % 4 == 0) ? 120 + (r / 4) % 81 : (r / 4) % 201;
            stable_cnt = 0;
        end else begin
            hold_cnt--;
        end
    endtask

    // MDIO bus monitor, counts cycles from reset release
    always @(posedge clk_125mhz_int) begin
        if (!gt_tx_reset) begin
            rel_cnt++;
            if (!mdio_t) begin
                if (run_len == 0) begin
                    frames_started++;
                end
                run_len++;
            end else if (run_len != 0) begin
                last_run = run_len;
                run_len  = 0;
            end
            assert (!(mdc && rel_cnt <= INIT_DELAY)) else
                report_failure("MDC toggled before the start-up delay ended");
            assert (!cfg_done || frames_started >= NUM_WRITES) else
                report_failure("cfg_done_o rose before the twelfth write was accepted");
            if (phy_frames > frames_checked) begin
                inspect_frame();
            end
            if (frames_checked == NUM_WRITES && !done_activity_seen) begin
                assert (!mdc && mdio_t) else begin
                    done_activity_seen = 1'b1;
                    report_failure("MDIO activity after the twelfth frame");
                end
            end
        end
    end

    always @(posedge clk_125mhz_int) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        gt_tx_reset = 1'b1;
        btn         = '0;
        sw          = '0;
        lane_lock   = '0;
        build_write_list();
        // registers are in reset from the first edge on
        @(posedge clk_125mhz_int);
        repeat (15) begin
            @(posedge clk_125mhz_int);
            verify_idle_outputs("reset");
        end
        gt_tx_reset <= 1'b0;
        repeat (4) begin
            @(posedge clk_125mhz_int);
            verify_idle_outputs("after reset");
        end
        while (!(frames_checked == NUM_WRITES && cfg_done)) begin
            drive_front_panel_step();
        end
        // long enough to catch a stray frame
        repeat (600) begin
            drive_front_panel_step();
        end
        assert (cfg_done) else report_failure("cfg_done_o dropped after completion");
        assert (led_checks > 0) else report_failure("led_o was never checked with settled inputs");
        print_counts();
        if (mismatches == 0 && failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/phy_mgmt_pkg.sv
rtl/phy_cfg_sequencer.sv
rtl/mdio_master.sv
rtl/board_io.sv
rtl/board_mgmt_top.sv
tb/mdio_phy_model.sv
tb/tb_board_mgmt.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the board management testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f vlog.f --top-module tb_board_mgmt -o sim_board_mgmt
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_board_mgmt)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints the pass line only when every check held
if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
